// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_scaler
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
scaler_pkg.sv
cubic_table.sv
scaler_regs.sv
scaler_h.sv
scaler_top.sv
tb_scaler.sv

// ==== cubic_table.sv ====
`default_nettype none

module cubic_table #(
    parameter int PIXEL_STEP = 4096,
    parameter int COE_WIDTH  = 10
) (
    input  logic                              clk,
    input  logic [$clog2(PIXEL_STEP)-3:0]     phase_i,
    output logic [3:0][COE_WIDTH-1:0]         coe_o
);

    localparam int     PH_W  = $clog2(PIXEL_STEP) - 2;
    localparam int     DEPTH = 1 << PH_W;
    localparam longint ONE   = longint'(1) << (COE_WIDTH - 1);

    typedef logic [3:0][COE_WIDTH-1:0] coe_set_t;

    // Catmull-Rom weights at t = p / DEPTH.
    // Tap 0 pairs with the newest sample, tap 3 with the oldest.
    function automatic coe_set_t coe_entry(input longint p);
        longint   n;
        longint   n3;
        longint   w0;
        longint   w1;
        longint   w2;
        longint   w3;
        coe_set_t c;
        n  = DEPTH;
        n3 = n * n * n;
        // Outer taps, negative in the sum.
        w0 = (p * p * (n - p) * ONE + n3) / (2 * n3);
        w3 = (p * (n - p) * (n - p) * ONE + n3) / (2 * n3);
        w1 = ((-3 * p * p * p + 4 * p * p * n + p * n * n) * ONE + n3) / (2 * n3);
        // Last inner tap absorbs rounding so weights sum to one exactly.
        w2 = ONE + w0 + w3 - w1;
        c[0] = COE_WIDTH'(w0);
        c[1] = COE_WIDTH'(w1);
        c[2] = COE_WIDTH'(w2);
        c[3] = COE_WIDTH'(w3);
        return c;
    endfunction

    coe_set_t rom [DEPTH];

    for (genvar i = 0; i < DEPTH; i++) begin : g_rom
        localparam coe_set_t ENTRY = coe_entry(longint'(i));
        assign rom[i] = ENTRY;
    end

    always_ff @(posedge clk) begin
        coe_o <= rom[phase_i];
    end

endmodule

`default_nettype wire

// ==== scaler_h.sv ====
`default_nettype none

module scaler_h #(
    parameter int PIXEL_STEP = 4096,
    parameter int COE_WIDTH  = 10
) (
    input  logic                    clk,
    input  logic                    rst_i,
    input  scaler_pkg::scaler_cfg_t cfg_i,
    input  scaler_pkg::pix_beat_t   vid_i,
    output scaler_pkg::pix_beat_t   vid_o,
    output logic                    frame_done_o
);
    import scaler_pkg::*;

    localparam int FRAC_W = $clog2(PIXEL_STEP);
    localparam int PH_W   = FRAC_W - 2;
    localparam int POS_W  = STEP_W + 8;
    localparam int MUL_W  = PIX_W + COE_WIDTH;
    localparam int ACC_W  = MUL_W + 2;
    localparam logic [ACC_W-1:0] ROUND = ACC_W'(1) << (COE_WIDTH - 2);

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } sync_t;

    logic [3:0][PIX_W-1:0]     win;
    logic [3:0][PIX_W-1:0]     tap_cap;
    logic [3:0][PIX_W-1:0]     tap_dly;
    logic [3:0][COE_WIDTH-1:0] coe;
    logic [3:0][MUL_W-1:0]     mul_q;
    logic [POS_W-1:0]          cnt_i;
    logic [POS_W-1:0]          cnt_o;
    logic [STEP_W-1:0]         step_q;
    logic [PH_W-1:0]           phase_q;
    logic                      sol;
    logic                      sof;
    logic                      line_start;
    logic                      take;
    sync_t                     s1;
    sync_t                     s2;
    sync_t                     s3;
    logic [ACC_W-1:0]          acc;
    logic [PIX_W-1:0]          pix_clamped;

    // Sample window, newest in slot 0.
    always_ff @(posedge clk) begin
        if (vid_i.de) begin
            win <= {win[2:0], vid_i.data};
        end
    end

    assign line_start = vid_i.de & vid_i.hs;
    assign take       = cfg_i.enable & ~line_start & (cnt_i > cnt_o);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_i  <= '0;
            cnt_o  <= POS_W'(PIXEL_STEP);
            step_q <= STEP_W'(PIXEL_STEP);
            sol    <= 1'b0;
            sof    <= 1'b0;
            s1     <= '0;
        end else begin
            s1 <= '0;
            if (take) begin
                s1    <= '{de: 1'b1, hs: sol, vs: sof};
                sol   <= 1'b0;
                sof   <= 1'b0;
                cnt_o <= cnt_o + POS_W'(step_q);
            end
            if (vid_i.de) begin
                cnt_i <= cnt_i + POS_W'(PIXEL_STEP);
                if (vid_i.vs) begin
                    sof <= 1'b1;
                end
            end
            // Step is only picked up at line start.
            if (line_start) begin
                cnt_i  <= '0;
                cnt_o  <= POS_W'(PIXEL_STEP);
                step_q <= cfg_i.step;
                sol    <= 1'b1;
            end
        end
    end

    // Window capture and phase.
    always_ff @(posedge clk) begin
        if (take) begin
            tap_cap[2:0] <= win[2:0];
            // Left edge repeats the first pixel.
            tap_cap[3]   <= (cnt_i <= POS_W'(2 * PIXEL_STEP)) ? win[2] : win[3];
            phase_q      <= cnt_o[FRAC_W-1 -: PH_W];
        end
    end

    cubic_table #(
        .PIXEL_STEP (PIXEL_STEP),
        .COE_WIDTH  (COE_WIDTH)
    ) u_cubic_table (
        .clk     (clk),
        .phase_i (phase_q),
        .coe_o   (coe)
    );

    // Window waits one cycle for the table, then multiply.
    always_ff @(posedge clk) begin
        tap_dly <= tap_cap;
        for (int i = 0; i < 4; i++) begin
            mul_q[i] <= coe[i] * tap_dly[i];
        end
    end

    always_comb begin
        acc = ACC_W'(mul_q[1]) + ACC_W'(mul_q[2]) - ACC_W'(mul_q[0])
            - ACC_W'(mul_q[3]) + ROUND;
        if (acc[ACC_W-1]) begin
            pix_clamped = '0;
        end else if (|acc[ACC_W-2:COE_WIDTH-1+PIX_W]) begin
            pix_clamped = '1;
        end else begin
            pix_clamped = acc[COE_WIDTH-1 +: PIX_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            s2           <= '0;
            s3           <= '0;
            vid_o        <= '0;
            frame_done_o <= 1'b0;
        end else begin
            s2       <= s1;
            s3       <= s2;
            vid_o.de <= s3.de;
            vid_o.hs <= s3.de & s3.hs;
            vid_o.vs <= s3.de & s3.vs;
            if (s3.de) begin
                vid_o.data <= pix_clamped;
            end
            frame_done_o <= s3.de & s3.vs;
        end
    end

    // A zero step from the register port would stall the line.
    a_step_nonzero: assert property (@(posedge clk) disable iff (rst_i)
        step_q != '0);

endmodule

`default_nettype wire

// ==== scaler_pkg.sv ====
`default_nettype none

package scaler_pkg;

    // Video sample format.
    localparam int PIX_W = 12;

    // Step is 4.12 unsigned fixed point.
    localparam int STEP_W = 16;

    // APB port widths.
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    // Register map.
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_STEP   = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h008;

    localparam int CTRL_EN_BIT = 0;

    // One beat of the raster stream.
    typedef struct packed {
        logic [PIX_W-1:0] data;
        logic             de;
        logic             hs;
        logic             vs;
    } pix_beat_t;

    // Configuration seen by the resampler.
    typedef struct packed {
        logic              enable;
        logic [STEP_W-1:0] step;
    } scaler_cfg_t;

endpackage

`default_nettype wire

// ==== scaler_regs.sv ====
`default_nettype none

module scaler_regs #(
    parameter int PIXEL_STEP = 4096
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [scaler_pkg::APB_AW-1:0]   paddr_i,
    input  logic [scaler_pkg::APB_DW-1:0]   pwdata_i,
    output logic [scaler_pkg::APB_DW-1:0]   prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    input  logic                            frame_done_i,
    output scaler_pkg::scaler_cfg_t         cfg_o
);
    import scaler_pkg::*;

    logic        access;
    logic        addr_ok;
    logic        wr_status;
    logic        wr_en;
    logic [15:0] frame_cnt;

    assign access    = psel_i & penable_i;
    assign addr_ok   = paddr_i inside {ADDR_CTRL, ADDR_STEP, ADDR_STATUS};
    assign wr_status = pwrite_i & (paddr_i == ADDR_STATUS);
    assign wr_en     = access & pwrite_i & addr_ok & ~wr_status;

    // Zero wait states.
    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~addr_ok | wr_status);

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            ADDR_CTRL:   prdata_o[CTRL_EN_BIT] = cfg_o.enable;
            ADDR_STEP:   prdata_o[STEP_W-1:0] = cfg_o.step;
            ADDR_STATUS: prdata_o[15:0] = frame_cnt;
            default:     prdata_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_o.enable <= 1'b0;
            cfg_o.step   <= STEP_W'(PIXEL_STEP);
        end else if (wr_en) begin
            if (paddr_i == ADDR_CTRL) begin
                cfg_o.enable <= pwdata_i[CTRL_EN_BIT];
            end
            if (paddr_i == ADDR_STEP) begin
                cfg_o.step <= pwdata_i[STEP_W-1:0];
            end
        end
    end

    // Output frames seen so far.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            frame_cnt <= '0;
        end else if (frame_done_i) begin
            frame_cnt <= frame_cnt + 16'd1;
        end
    end

    // Access phase must follow a setup phase.
    a_apb_setup: assert property (@(posedge clk) disable iff (rst_i)
        penable_i |-> $past(psel_i & ~penable_i));

endmodule

`default_nettype wire

// ==== scaler_top.sv ====
`default_nettype none

module scaler_top #(
    parameter int PIXEL_STEP = 4096,
    parameter int COE_WIDTH  = 10
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            psel_i,
    input  logic                            penable_i,
    input  logic                            pwrite_i,
    input  logic [scaler_pkg::APB_AW-1:0]   paddr_i,
    input  logic [scaler_pkg::APB_DW-1:0]   pwdata_i,
    output logic [scaler_pkg::APB_DW-1:0]   prdata_o,
    output logic                            pready_o,
    output logic                            pslverr_o,
    input  scaler_pkg::pix_beat_t           vid_i,
    output scaler_pkg::pix_beat_t           vid_o
);
    import scaler_pkg::*;

    scaler_cfg_t cfg;
    logic        frame_done;

    scaler_regs #(
        .PIXEL_STEP (PIXEL_STEP)
    ) u_scaler_regs (
        .clk          (clk),
        .rst_i        (rst_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .frame_done_i (frame_done),
        .cfg_o        (cfg)
    );

    scaler_h #(
        .PIXEL_STEP (PIXEL_STEP),
        .COE_WIDTH  (COE_WIDTH)
    ) u_scaler_h (
        .clk          (clk),
        .rst_i        (rst_i),
        .cfg_i        (cfg),
        .vid_i        (vid_i),
        .vid_o        (vid_o),
        .frame_done_o (frame_done)
    );

endmodule

`default_nettype wire

// ==== tb_scaler.sv ====
`default_nettype none

module tb_scaler;
    timeunit 1ns;
    timeprecision 100ps;

    import scaler_pkg::*;

    localparam int PIXEL_STEP = 4096;
    localparam int COE_WIDTH  = 10;
    localparam int APB_LIMIT  = 16;
    localparam int IDLE_LIMIT = 48;
    localparam int LINE_LIMIT = 4000;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    pix_beat_t         vid_in;
    pix_beat_t         vid_out;

    pix_beat_t   rx_q[$];
    logic [31:0] seed;
    int          n_checks;
    int          n_errors;
    int          beats_sent;
    int          frames_sent;

    scaler_top #(
        .PIXEL_STEP (PIXEL_STEP),
        .COE_WIDTH  (COE_WIDTH)
    ) u_scaler_top (
        .clk       (clk),
        .rst_i     (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .vid_i     (vid_in),
        .vid_o     (vid_out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Count of k >= 0 with PIXEL_STEP + k * step below the line's end position.
    function automatic int expected_outputs(input int width, input int step);
        longint pos;
        int     n;
        pos = longint'(PIXEL_STEP);
        n   = 0;
        while (pos < longint'(width - 1) * longint'(PIXEL_STEP)) begin
            n++;
            pos += longint'(step);
        end
        return n;
    endfunction

    task automatic check_beat(input string name, input pix_beat_t exp, input pix_beat_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!pready && waited < APB_LIMIT);
        if (!pready) begin
            n_errors++;
            $display("APB transfer to address %h never saw pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rd;
        apb_transfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic send_line(input int width, input int gap, input logic sof,
                             input logic flat, input logic [PIX_W-1:0] level);
        logic [31:0]      r;
        logic [PIX_W-1:0] px;
        for (int i = 0; i < width; i++) begin
            @(posedge clk);
            r  = lcg_next();
            px = flat ? level : r[27:16];
            vid_in <= '{data: px, de: 1'b1, hs: (i == 0), vs: sof && (i == 0)};
            beats_sent++;
            repeat (gap) begin
                @(posedge clk);
                vid_in <= '0;
            end
        end
        @(posedge clk);
        vid_in <= '0;
    endtask

    // Line is over once the output has been idle for a while.
    task automatic collect_line();
        int idle;
        int total;
        rx_q.delete();
        idle  = 0;
        total = 0;
        while (idle < IDLE_LIMIT && total < LINE_LIMIT) begin
            @(negedge clk);
            total++;
            if (vid_out.de) begin
                rx_q.push_back(vid_out);
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (total >= LINE_LIMIT) begin
            n_errors++;
            $display("Output stream did not go idle within %0d cycles", LINE_LIMIT);
        end
    endtask

    task automatic run_line(input int width, input logic sof, input logic flat,
                            input logic [PIX_W-1:0] level);
        beats_sent = 0;
        fork
            send_line(width, 4, sof, flat, level);
            collect_line();
        join
    endtask

    task automatic check_line(input string name, input int width, input int step,
                              input logic sof, input logic flat,
                              input logic [PIX_W-1:0] level);
        pix_beat_t exp;
        check_count({name, " count"}, expected_outputs(width, step), rx_q.size());
        foreach (rx_q[i]) begin
            exp = '{data: level, de: 1'b1, hs: (i == 0), vs: sof && (i == 0)};
            if (flat) begin
                check_beat($sformatf("%s beat %0d", name, i), exp, rx_q[i]);
            end else begin
                check_word($sformatf("%s flags %0d", name, i),
                           {29'd0, exp.de, exp.hs, exp.vs},
                           {29'd0, rx_q[i].de, rx_q[i].hs, rx_q[i].vs});
            end
        end
        if (sof && expected_outputs(width, step) > 0) begin
            frames_sent++;
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rd;
        logic        err;
        check_beat("reset vid_o", '0, vid_out);
        apb_read(ADDR_CTRL, rd, err);
        check_word("reset CTRL", 32'd0, rd);
        apb_read(ADDR_STEP, rd, err);
        check_word("reset STEP", 32'(PIXEL_STEP), rd);
        apb_read(ADDR_STATUS, rd, err);
        check_word("reset STATUS", 32'd0, rd);
        run_line(16, 1'b0, 1'b0, '0);
        check_count("disabled line", 0, rx_q.size());
        // One-beat line parks the position counters before enabling.
        run_line(1, 1'b0, 1'b0, '0);
        check_count("parking line", 0, rx_q.size());
    endtask

    task automatic test_register_access();
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_STEP, 32'h1800, err);
        check_word("STEP write pslverr", 32'd0, 32'(err));
        apb_read(ADDR_STEP, rd, err);
        check_word("STEP read-back", 32'h1800, rd);
        apb_write(12'h00C, 32'hffff_ffff, err);
        check_word("write 0xC pslverr", 32'd1, 32'(err));
        apb_read(12'h00C, rd, err);
        check_word("read 0xC pslverr", 32'd1, 32'(err));
        apb_write(ADDR_STATUS, 32'h55, err);
        check_word("write STATUS pslverr", 32'd1, 32'(err));
        apb_read(ADDR_CTRL, rd, err);
        check_word("CTRL after bad access", 32'd0, rd);
        apb_read(ADDR_STEP, rd, err);
        check_word("STEP after bad access", 32'h1800, rd);
        apb_read(ADDR_STATUS, rd, err);
        check_word("STATUS after bad access", 32'd0, rd);
    endtask

    task automatic test_flat_lines();
        int          steps[3] = '{4096, 2048, 8192};
        logic [31:0] r;
        logic        err;
        apb_write(ADDR_CTRL, 32'd1 << CTRL_EN_BIT, err);
        foreach (steps[s]) begin
            apb_write(ADDR_STEP, 32'(steps[s]), err);
            r = lcg_next();
            run_line(16, 1'b1, 1'b1, r[11:0]);
            check_line($sformatf("flat step %0d", steps[s]), 16, steps[s], 1'b1, 1'b1,
                       r[11:0]);
        end
    endtask

    task automatic test_line_counts();
        int   steps[7] = '{4096, 2048, 1024, 8192, 6144, 12288, 5000};
        logic err;
        foreach (steps[s]) begin
            apb_write(ADDR_STEP, 32'(steps[s]), err);
            run_line(20, 1'b0, 1'b0, '0);
            check_line($sformatf("count step %0d", steps[s]), 20, steps[s], 1'b0, 1'b0, '0);
        end
    endtask

    task automatic test_frames();
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_STEP, 32'(PIXEL_STEP), err);
        for (int f = 0; f < 3; f++) begin
            for (int l = 0; l < 2; l++) begin
                run_line(12, (l == 0), 1'b0, '0);
                check_line($sformatf("frame %0d line %0d", f, l), 12, PIXEL_STEP, (l == 0),
                           1'b0, '0);
            end
        end
        apb_read(ADDR_STATUS, rd, err);
        check_word("STATUS frame count", 32'(frames_sent), rd);
    endtask

    task automatic test_step_change();
        logic [31:0] rd;
        logic        err;
        int          waited;
        apb_write(ADDR_STEP, 32'(PIXEL_STEP), err);
        beats_sent = 0;
        fork
            send_line(20, 4, 1'b0, 1'b0, '0);
            collect_line();
            begin
                waited = 0;
                while (beats_sent < 10 && waited < 400) begin
                    @(posedge clk);
                    waited++;
                end
                if (beats_sent < 10) begin
                    n_errors++;
                    $display("Line never reached its middle before the step write");
                end
                apb_write(ADDR_STEP, 32'd2048, err);
            end
        join
        check_line("old step line", 20, PIXEL_STEP, 1'b0, 1'b0, '0);
        run_line(20, 1'b0, 1'b0, '0);
        check_line("new step line", 20, 2048, 1'b0, 1'b0, '0);
        apb_read(ADDR_STEP, rd, err);
        check_word("STEP after change", 32'd2048, rd);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        vid_in      = '0;
        seed        = 32'h15f8a855;
        n_checks    = 0;
        n_errors    = 0;
        beats_sent  = 0;
        frames_sent = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_register_access();
        test_flat_lines();
        test_line_counts();
        test_frames();
        test_step_change();
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (100000) @(posedge clk);
        $display("Simulation did not finish within 100000 cycles");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
